// ==== tb/bridge_trace.txt ====
# op address wdata expected_rdata, all hex
# op: W write, B write with no idle gap, R read, I idle cycle
R 80000010 00000000 00000000
W 80000010 11111111 00000000
R 80000010 00000000 11111111
W 84000020 22222222 00000000
W 88000030 33333333 00000000
B 88000034 44444444 00000000
B 80000040 55555555 00000000
I 80000000 00000000 00000000
W 90000000 deadbeef 00000000
R 90000000 00000000 00000000
R 84000020 00000000 22222222
R 88000034 00000000 44444444
R 80000040 00000000 55555555
W 8400003c 66666666 00000000
R 8400003c 00000000 66666666
R 88000030 00000000 33333333

// ==== sim.f ====
+incdir+logic
logic/ahbTypesPkg.sv
logic/apbTypesPkg.sv
logic/ahbSlaveInterface.sv
logic/apbFsmController.sv
logic/apbReadReturn.sv
logic/ahbApbBridge.sv
tb/bridge_assert.sv
tb/bridgeChecker.sv
tb/bridgeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert -j 0 --top-module bridgeTb -f sim.f -o bridgeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/bridgeSim)"
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
else
	exit 1
fi

// ==== tb/bridgeTb.sv ====
// Memory models decode Paddr[9:2] only, so trace addresses stay below offset 0x400 in a window
`default_nettype none
`include "bridge_defines.svh"

module bridgeTb;

	logic Hclk;
	logic Hresetn;
	ahbTypesPkg::addr_t Haddr;
	ahbTypesPkg::htrans_t Htrans;
	logic Hwrite;
	ahbTypesPkg::data_t Hwdata;
	logic Hreadyin;
	logic Hreadyout;
	ahbTypesPkg::data_t Hrdata;
	logic Hresp;
	ahbTypesPkg::data_t prdata0;
	ahbTypesPkg::data_t prdata1;
	ahbTypesPkg::data_t prdata2;
	ahbTypesPkg::addr_t Paddr;
	ahbTypesPkg::data_t Pwdata;
	logic Pwrite;
	apbTypesPkg::psel_t Pselx;
	logic Penable;
	ahbTypesPkg::data_t expRdata;

	int valueErrors;
	int protocolErrors;
	int pendingCount;

	string opList [$];
	ahbTypesPkg::addr_t addrList [$];
	ahbTypesPkg::data_t wdataList [$];
	ahbTypesPkg::data_t rdataList [$];
	logic traceLoaded = 1'b0;

	ahbTypesPkg::data_t periphMem [`NUM_SLAVES][256];

	ahbApbBridge UUT (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hwdata(Hwdata),
		.Hreadyin(Hreadyin),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata),
		.Hresp(Hresp),
		.prdata0(prdata0),
		.prdata1(prdata1),
		.prdata2(prdata2),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Pwrite(Pwrite),
		.Pselx(Pselx),
		.Penable(Penable)
	);

	bridgeChecker scoreboard (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hwdata(Hwdata),
		.Hreadyin(Hreadyin),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata),
		.Hresp(Hresp),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Pwrite(Pwrite),
		.Pselx(Pselx),
		.Penable(Penable),
		.expRdata(expRdata),
		.valueErrors(valueErrors),
		.protocolErrors(protocolErrors),
		.pendingCount(pendingCount)
	);

	initial
		Hclk = 1'b0;

	always #10 Hclk = ~Hclk;

	// Single slave on the bus
	assign Hreadyin = Hreadyout;

	// APB memory models, written in the enable cycle
	assign prdata0 = periphMem[0][Paddr[9:2]];
	assign prdata1 = periphMem[1][Paddr[9:2]];
	assign prdata2 = periphMem[2][Paddr[9:2]];

	always @(posedge Hclk)
	begin
		for (int i = 0; i < `NUM_SLAVES; i++)
			if (Pselx[i] && Penable && Pwrite)
				periphMem[i][Paddr[9:2]] <= Pwdata;
	end

	function automatic bit loadTrace();
		int fd;
		int n;
		string line;
		string op;
		ahbTypesPkg::addr_t a;
		ahbTypesPkg::data_t w;
		ahbTypesPkg::data_t r;
		fd = $fopen("tb/bridge_trace.txt", "r");
		if (fd == 0)
			return 1'b0;
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			// Comment and blank lines fail the scan
			if (n > 0 && $sscanf(line, "%s %h %h %h", op, a, w, r) == 4)
			begin
				opList.push_back(op);
				addrList.push_back(a);
				wdataList.push_back(w);
				rdataList.push_back(r);
			end
		end
		$fclose(fd);
		return 1'b1;
	endfunction

	// One AHB transfer, starting and ending on a falling edge
	task automatic driveTransfer(input int k);
		int gap;
		logic isWrite;
		isWrite = (opList[k] == "W" || opList[k] == "B");
		gap = (opList[k] == "B") ? 0 : int'($urandom % 3);
		repeat (gap) @(negedge Hclk);
		while (!Hreadyout)
			@(negedge Hclk);
		Haddr = addrList[k];
		Hwrite = isWrite;
		Htrans = (opList[k] == "I") ? ahbTypesPkg::IDLE : ahbTypesPkg::NONSEQ;
		expRdata = rdataList[k];
		@(negedge Hclk);
		// Data phase
		Htrans = ahbTypesPkg::IDLE;
		if (isWrite)
			Hwdata = wdataList[k];
	endtask

	task automatic printCounts();
		$display("Errors: %0d value, %0d protocol, %0d assertion, %0d unmatched AHB transfers",
			valueErrors, protocolErrors, UUT.protocolChecks.failCount, pendingCount);
	endtask

	task automatic stopWithFailure();
		$display("Testbench failed");
		$finish;
	endtask

	initial
	begin
		void'($urandom(99));
		Hresetn = 1'b0;
		Haddr = '0;
		Htrans = ahbTypesPkg::IDLE;
		Hwrite = 1'b0;
		Hwdata = '0;
		expRdata = '0;
		for (int i = 0; i < `NUM_SLAVES; i++)
			for (int j = 0; j < 256; j++)
				periphMem[i][j] = '0;
		if (!loadTrace())
		begin
			$display("Cannot open trace file tb/bridge_trace.txt");
			stopWithFailure();
		end
		else
		begin
			traceLoaded = 1'b1;
			repeat (10) @(negedge Hclk);
			Hresetn = 1'b1;
			@(negedge Hclk);
			for (int k = 0; k < opList.size(); k++)
				driveTransfer(k);
			while (!Hreadyout)
				@(negedge Hclk);
			repeat (6) @(negedge Hclk);
			printCounts();
			if (valueErrors + protocolErrors + UUT.protocolChecks.failCount + pendingCount == 0)
			begin
				$display("Testbench passed");
				$finish;
			end
			else
				stopWithFailure();
		end
	end

	// Watchdog, 20 cycles per trace line plus reset
	initial
	begin
		wait (traceLoaded);
		#((opList.size() * 20 + 10) * 20);
		$display("Timeout: the run did not finish within %0d cycles", opList.size() * 20 + 10);
		printCounts();
		stopWithFailure();
	end

endmodule

`default_nettype wire

// ==== tb/bridgeChecker.sv ====
// Assumes Hreadyin follows Hreadyout and that APB transfers complete in AHB issue order
`default_nettype none
`include "bridge_defines.svh"

module bridgeChecker (
	input logic Hclk,
	input logic Hresetn,
	input ahbTypesPkg::addr_t Haddr,
	input ahbTypesPkg::htrans_t Htrans,
	input logic Hwrite,
	input ahbTypesPkg::data_t Hwdata,
	input logic Hreadyin,
	input logic Hreadyout,
	input ahbTypesPkg::data_t Hrdata,
	input logic Hresp,
	input ahbTypesPkg::addr_t Paddr,
	input ahbTypesPkg::data_t Pwdata,
	input logic Pwrite,
	input apbTypesPkg::psel_t Pselx,
	input logic Penable,
	input ahbTypesPkg::data_t expRdata,
	output int valueErrors,
	output int protocolErrors,
	output int pendingCount
);

	ahbTypesPkg::addr_t addrQ [$];
	logic writeQ [$];
	ahbTypesPkg::data_t dataQ [$];
	ahbTypesPkg::data_t refMem [ahbTypesPkg::addr_t];

	logic dataDue = 1'b0;
	logic readDue = 1'b0;
	ahbTypesPkg::data_t readExp;
	logic rstQ = 1'b0;
	logic rstPrev = 1'b0;

	initial
	begin
		valueErrors = 0;
		protocolErrors = 0;
		pendingCount = 0;
	end

	// Peripheral window of an address, none when out of range
	function automatic apbTypesPkg::psel_t windowOf(input ahbTypesPkg::addr_t addr);
		apbTypesPkg::psel_t sel;
		sel = '0;
		if (addr >= `SLAVE0_BASE && addr < `SLAVE0_BASE + `SLAVE_SPAN)
			sel = 3'b001;
		if (addr >= `SLAVE1_BASE && addr < `SLAVE1_BASE + `SLAVE_SPAN)
			sel = 3'b010;
		if (addr >= `SLAVE2_BASE && addr < `SLAVE2_BASE + `SLAVE_SPAN)
			sel = 3'b100;
		return sel;
	endfunction

	// AHB side, inputs are stable at the rising edge
	always @(posedge Hclk)
	begin
		rstQ <= Hresetn;
		if (!Hresetn)
			dataDue = 1'b0;
		else
		begin
			// Write data arrives one cycle after its address
			if (dataDue)
			begin
				dataQ.push_back(Hwdata);
				dataDue = 1'b0;
			end
			if (Hreadyin && (Htrans == ahbTypesPkg::NONSEQ || Htrans == ahbTypesPkg::SEQ)
				&& windowOf(Haddr) != '0)
			begin
				addrQ.push_back(Haddr);
				writeQ.push_back(Hwrite);
				if (Hwrite)
					dataDue = 1'b1;
				else
					dataQ.push_back(expRdata);
			end
		end
	end

	// DUT outputs, sampled between rising edges
	always @(negedge Hclk)
	begin
		ahbTypesPkg::addr_t addr;
		ahbTypesPkg::data_t data;
		ahbTypesPkg::data_t refVal;
		logic isWrite;
		if (!rstQ)
		begin
			if (Pselx != '0 || Penable || Pwrite)
			begin
				$display("APB outputs not low during reset at time %0t", $time);
				protocolErrors++;
			end
		end
		else
		begin
			if (!rstPrev && !Hreadyout)
			begin
				$display("Hreadyout not high after reset release at time %0t", $time);
				protocolErrors++;
			end
			if (Hresp != ahbTypesPkg::hrespOkay)
			begin
				$display("[ERROR] %0t: Hresp is not OKAY", $time);
				valueErrors++;
			end
			if (readDue)
			begin
				readDue = 1'b0;
				if (Hrdata != readExp || !Hreadyout)
				begin
					$display("[ERROR] %0t: Hrdata %h, expected %h with Hreadyout high",
						$time, Hrdata, readExp);
					valueErrors++;
				end
			end
			if (Penable && Pselx != '0)
			begin
				if (addrQ.size() == 0 || dataQ.size() == 0)
				begin
					$display("APB transfer at time %0t has no matching AHB transfer", $time);
					protocolErrors++;
				end
				else
				begin
					addr = addrQ.pop_front();
					isWrite = writeQ.pop_front();
					data = dataQ.pop_front();
					if (Paddr != addr || Pwrite != isWrite || Pselx != windowOf(addr))
					begin
						$display("[ERROR] %0t: APB %h write %0b sel %b, expected %h write %0b sel %b",
							$time, Paddr, Pwrite, Pselx, addr, isWrite, windowOf(addr));
						valueErrors++;
					end
					if (isWrite)
					begin
						if (Pwdata != data)
						begin
							$display("[ERROR] %0t: Pwdata %h, expected %h", $time, Pwdata, data);
							valueErrors++;
						end
						refMem[addr] = data;
					end
					else
					begin
						refVal = refMem.exists(addr) ? refMem[addr] : '0;
						if (refVal != data)
						begin
							$display("[ERROR] %0t: trace expects %h at %h, reference holds %h",
								$time, data, addr, refVal);
							valueErrors++;
						end
						readExp = data;
						readDue = 1'b1;
					end
				end
			end
		end
		rstPrev = rstQ;
		pendingCount = addrQ.size();
	end

endmodule

`default_nettype wire

// ==== tb/bridge_assert.sv ====
// APB2 rules only, checked while Hresetn is high, and with no Pready or Pslverr to look at
`default_nettype none

module bridgeAssert (
	input logic Hclk,
	input logic Hresetn,
	input apbTypesPkg::psel_t Pselx,
	input logic Penable,
	input ahbTypesPkg::addr_t Paddr
);

	int failCount = 0;

	// Enable only straight after a setup cycle to the same peripheral
	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> ($past(!Penable) && ($past(Pselx) != '0) && (Pselx == $past(Pselx))))
	else
	begin
		failCount = failCount + 1;
		$error("Penable high without a setup cycle to the same peripheral");
	end

	// Address held from setup into enable
	addrStable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> (Paddr == $past(Paddr)))
	else
	begin
		failCount = failCount + 1;
		$error("Paddr changed between setup and enable");
	end

	selOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$onehot0(Pselx))
	else
	begin
		failCount = failCount + 1;
		$error("More than one Pselx bit set");
	end

endmodule

bind ahbApbBridge bridgeAssert protocolChecks (
	.Hclk(Hclk),
	.Hresetn(Hresetn),
	.Pselx(Pselx),
	.Penable(Penable),
	.Paddr(Paddr)
);

`default_nettype wire

// ==== logic/ahbApbBridge.sv ====
// Single AHB-Lite slave whose Hreadyin follows Hreadyout, driving three APB2 peripherals
`default_nettype none

module ahbApbBridge (
	input logic Hclk,
	input logic Hresetn,
	input ahbTypesPkg::addr_t Haddr,
	input ahbTypesPkg::htrans_t Htrans,
	input logic Hwrite,
	input ahbTypesPkg::data_t Hwdata,
	input logic Hreadyin,
	output logic Hreadyout,
	output ahbTypesPkg::data_t Hrdata,
	output logic Hresp,
	input ahbTypesPkg::data_t prdata0,
	input ahbTypesPkg::data_t prdata1,
	input ahbTypesPkg::data_t prdata2,
	output ahbTypesPkg::addr_t Paddr,
	output ahbTypesPkg::data_t Pwdata,
	output logic Pwrite,
	output apbTypesPkg::psel_t Pselx,
	output logic Penable
);

	logic valid;
	logic hwriteReg;
	apbTypesPkg::psel_t tempSel;
	ahbTypesPkg::addr_t haddr1;
	ahbTypesPkg::addr_t haddr2;
	ahbTypesPkg::data_t hwdata1;

	ahbSlaveInterface ahbSide (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hwdata(Hwdata),
		.Hreadyin(Hreadyin),
		.valid(valid),
		.tempSel(tempSel),
		.haddr1(haddr1),
		.haddr2(haddr2),
		.hwdata1(hwdata1),
		.hwriteReg(hwriteReg)
	);

	apbFsmController apbCtrl (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.valid(valid),
		.Haddr(Haddr),
		.haddr1(haddr1),
		.haddr2(haddr2),
		.Hwdata(Hwdata),
		.hwdata1(hwdata1),
		.Hwrite(Hwrite),
		.hwriteReg(hwriteReg),
		.tempSel(tempSel),
		.Pwrite(Pwrite),
		.Penable(Penable),
		.Pselx(Pselx),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Hreadyout(Hreadyout)
	);

	apbReadReturn readSide (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Pselx(Pselx),
		.Penable(Penable),
		.Pwrite(Pwrite),
		.prdata0(prdata0),
		.prdata1(prdata1),
		.prdata2(prdata2),
		.Hrdata(Hrdata),
		.Hresp(Hresp)
	);

endmodule

`default_nettype wire

// ==== logic/apbReadReturn.sv ====
// Hrdata changes only after a read enable cycle and Hresp is always OKAY
`default_nettype none

module apbReadReturn (
	input logic Hclk,
	input logic Hresetn,
	input apbTypesPkg::psel_t Pselx,
	input logic Penable,
	input logic Pwrite,
	input ahbTypesPkg::data_t prdata0,
	input ahbTypesPkg::data_t prdata1,
	input ahbTypesPkg::data_t prdata2,
	output ahbTypesPkg::data_t Hrdata,
	output logic Hresp
);

	ahbTypesPkg::data_t rdMux;
	logic readEnable;

	// Pselx is one-hot
	always_comb
	begin
		rdMux = '0;
		case (Pselx)
			3'b001:
				rdMux = prdata0;
			3'b010:
				rdMux = prdata1;
			3'b100:
				rdMux = prdata2;
			default:
				rdMux = '0;
		endcase
	end

	assign readEnable = Penable && !Pwrite && (Pselx != '0);

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Hrdata <= '0;
			Hresp <= ahbTypesPkg::hrespOkay;
		end
		else
		begin
			if (readEnable)
				Hrdata <= rdMux;
			Hresp <= ahbTypesPkg::hrespOkay;
		end
	end

endmodule

`default_nettype wire

// ==== logic/apbFsmController.sv ====
// APB2 timing with no wait states, no Pready or Pslverr, and at most two writes in flight
`default_nettype none

module apbFsmController (
	input logic Hclk,
	input logic Hresetn,
	input logic valid,
	input ahbTypesPkg::addr_t Haddr,
	input ahbTypesPkg::addr_t haddr1,
	input ahbTypesPkg::addr_t haddr2,
	input ahbTypesPkg::data_t Hwdata,
	input ahbTypesPkg::data_t hwdata1,
	input logic Hwrite,
	input logic hwriteReg,
	input apbTypesPkg::psel_t tempSel,
	output logic Pwrite,
	output logic Penable,
	output apbTypesPkg::psel_t Pselx,
	output ahbTypesPkg::addr_t Paddr,
	output ahbTypesPkg::data_t Pwdata,
	output logic Hreadyout
);

	apbTypesPkg::apbState_t state;
	apbTypesPkg::apbState_t stateNext;

	ahbTypesPkg::addr_t addrNext;
	ahbTypesPkg::data_t wdataNext;
	apbTypesPkg::psel_t selNext;
	logic writeNext;
	logic enableNext;
	logic readyNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= apbTypesPkg::stIdle;
		else
			state <= stateNext;
	end

	always_comb
	begin
		stateNext = state;
		case (state)
			apbTypesPkg::stWriteWait:
				stateNext = valid ? apbTypesPkg::stWritePipe : apbTypesPkg::stWrite;
			apbTypesPkg::stRead:
				stateNext = apbTypesPkg::stReadEnable;
			apbTypesPkg::stWrite:
				stateNext = apbTypesPkg::stWriteEnable;
			apbTypesPkg::stWritePipe:
				stateNext = apbTypesPkg::stWritePipeEnable;
			// Parked transfer in haddr2 decides where to go
			apbTypesPkg::stWritePipeEnable:
				stateNext = hwriteReg ? apbTypesPkg::stWrite : apbTypesPkg::stRead;
			// Idle and both enable states take a new address phase
			default:
			begin
				if (!valid)
					stateNext = apbTypesPkg::stIdle;
				else if (Hwrite)
					stateNext = apbTypesPkg::stWriteWait;
				else
					stateNext = apbTypesPkg::stRead;
			end
		endcase
	end

	// Decode of the values the APB bus carries next cycle
	always_comb
	begin
		addrNext = Paddr;
		wdataNext = Pwdata;
		writeNext = Pwrite;
		selNext = '0;
		enableNext = 1'b0;
		readyNext = 1'b1;
		case (state)
			apbTypesPkg::stWriteWait:
			begin
				// Write data is on Hwdata now, address came one cycle earlier
				addrNext = haddr1;
				wdataNext = Hwdata;
				writeNext = hwriteReg;
				selNext = apbTypesPkg::decodeSel(haddr1);
				readyNext = 1'b0;
			end
			apbTypesPkg::stRead,
			apbTypesPkg::stWritePipe:
			begin
				selNext = Pselx;
				enableNext = 1'b1;
				readyNext = 1'b0;
			end
			apbTypesPkg::stWrite:
			begin
				selNext = Pselx;
				enableNext = 1'b1;
			end
			apbTypesPkg::stWritePipeEnable:
			begin
				// Second transfer waited two cycles back
				addrNext = haddr2;
				wdataNext = hwdata1;
				writeNext = hwriteReg;
				selNext = apbTypesPkg::decodeSel(haddr2);
				readyNext = 1'b0;
			end
			default:
			begin
				// read setup straight from the address phase
				if (valid && !Hwrite)
				begin
					addrNext = Haddr;
					selNext = tempSel;
					writeNext = 1'b0;
					readyNext = 1'b0;
				end
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Pselx <= '0;
			Penable <= 1'b0;
			Pwrite <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			Pselx <= selNext;
			Penable <= enableNext;
			Pwrite <= writeNext;
			Hreadyout <= readyNext;
		end
	end

	// Payload outputs
	always_ff @(posedge Hclk)
	begin
		Paddr <= addrNext;
		Pwdata <= wdataNext;
	end

endmodule

`default_nettype wire

// ==== logic/ahbSlaveInterface.sv ====
// Hreadyin must follow Hreadyout because an address phase is only taken while it is high
`default_nettype none

module ahbSlaveInterface (
	input logic Hclk,
	input logic Hresetn,
	input ahbTypesPkg::addr_t Haddr,
	input ahbTypesPkg::htrans_t Htrans,
	input logic Hwrite,
	input ahbTypesPkg::data_t Hwdata,
	input logic Hreadyin,
	output logic valid,
	output apbTypesPkg::psel_t tempSel,
	output ahbTypesPkg::addr_t haddr1,
	output ahbTypesPkg::addr_t haddr2,
	output ahbTypesPkg::data_t hwdata1,
	output logic hwriteReg
);

	logic active;

	// Only NONSEQ and SEQ carry a transfer
	always_comb
	begin
		active = 1'b0;
		case (Htrans)
			ahbTypesPkg::NONSEQ,
			ahbTypesPkg::SEQ:
				active = 1'b1;
			ahbTypesPkg::IDLE,
			ahbTypesPkg::BUSY:
				active = 1'b0;
		endcase
	end

	assign tempSel = apbTypesPkg::decodeSel(Haddr);

	// In-range transfer seen in an address phase
	assign valid = active && Hreadyin && (tempSel != '0);

	// Delay line feeding the pipelined write path
	always_ff @(posedge Hclk)
	begin
		haddr1 <= Haddr;
		haddr2 <= haddr1;
		hwdata1 <= Hwdata;
	end

	// Direction of the last accepted transfer, held until the next one
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			hwriteReg <= 1'b0;
		else if (valid)
			hwriteReg <= Hwrite;
	end

endmodule

`default_nettype wire

// ==== logic/apbTypesPkg.sv ====
// APB2 select and controller state types for three peripherals at fixed windows
`default_nettype none
`include "bridge_defines.svh"

package apbTypesPkg;

	// One bit per peripheral
	typedef logic [`NUM_SLAVES-1:0] psel_t;

	typedef enum logic [2:0] {
		stIdle = 3'd0,
		stWriteWait = 3'd1,
		stRead = 3'd2,
		stWrite = 3'd3,
		stWritePipe = 3'd4,
		stReadEnable = 3'd5,
		stWriteEnable = 3'd6,
		stWritePipeEnable = 3'd7
	} apbState_t;

	localparam ahbTypesPkg::addr_t slaveBase [`NUM_SLAVES] =
		'{`SLAVE0_BASE, `SLAVE1_BASE, `SLAVE2_BASE};

	// Out-of-range addresses decode to no select
	function automatic psel_t decodeSel(input ahbTypesPkg::addr_t addr);
		psel_t sel;
		sel = '0;
		for (int i = 0; i < `NUM_SLAVES; i++)
			sel[i] = (addr - slaveBase[i]) < `SLAVE_SPAN;
		return sel;
	endfunction

endpackage

`default_nettype wire

// ==== logic/ahbTypesPkg.sv ====
// AHB-Lite types for a 32-bit bus without HSIZE, HPROT, bursts or error responses
`default_nettype none
`include "bridge_defines.svh"

package ahbTypesPkg;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DATA_WIDTH-1:0] data_t;

	// HTRANS encoding
	typedef logic [1:0] htrans_t;

	localparam htrans_t IDLE = 2'b00;
	localparam htrans_t BUSY = 2'b01;
	localparam htrans_t NONSEQ = 2'b10;
	localparam htrans_t SEQ = 2'b11;

	// Single-bit HRESP of AHB-Lite
	localparam logic hrespOkay = 1'b0;

endpackage

`default_nettype wire

// ==== logic/bridge_defines.svh ====
// Bus widths are fixed at 32 bits and the three 64 MB peripheral windows must not overlap
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// APB peripherals behind the bridge
`define NUM_SLAVES 3

// Window base of each peripheral
`define SLAVE0_BASE 32'h8000_0000
`define SLAVE1_BASE 32'h8400_0000
`define SLAVE2_BASE 32'h8800_0000

// Size of one window
`define SLAVE_SPAN 32'h0400_0000

`endif
